// ==== tb.f ====
+incdir+.
axi_mux_pkg.sv
rr_arbiter.sv
aw_channel_ctrl.sv
w_route_fifo.sv
w_channel_mux.sv
b_resp_router.sv
axi_write_mux.sv
axi_write_mux_assert.sv
tb_axi_write_mux.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the write multiplexer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_write_mux \
  -f tb.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No verdict found in $LOG"
  exit 1
fi
exit 0

// ==== tb_axi_write_mux.sv ====
// Testbench of the AXI4 write multiplexer
// Table of writes on four peer ports, slave model with random stalls, checks per channel

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module tb_axi_write_mux;
  import axi_mux_pkg::*;

  localparam int NP      = `AXI_MUX_NUM_PORTS;
  localparam int N_WR    = 12;
  localparam int RST_CYC = 16;
  localparam int W_HOLD  = 40;                     // Shared W port held off after reset
  localparam int LIMIT   = 200 * N_WR + RST_CYC;

  typedef struct packed {
    logic [1:0]  port;
    logic [2:0]  id;
    logic [15:0] addr;
    logic [3:0]  beats;
    logic [31:0] data;   // First beat, later beats count up
    logic [1:0]  resp;
    logic [4:0]  mid;    // Expected ID at the shared port
  } entry_t;

  // First four entries hit all ports at once
  entry_t tbl [N_WR] = '{
    '{2'd0, 3'd5, 16'h1000, 4'd4, 32'hA000_0000, 2'd0, 5'b00_101},
    '{2'd1, 3'd2, 16'h2040, 4'd2, 32'hB100_0010, 2'd1, 5'b01_010},
    '{2'd2, 3'd7, 16'h3100, 4'd1, 32'hC200_0020, 2'd2, 5'b10_111},
    '{2'd3, 3'd0, 16'h4200, 4'd3, 32'hD300_0030, 2'd3, 5'b11_000},
    '{2'd2, 3'd1, 16'h3180, 4'd3, 32'hC200_0100, 2'd0, 5'b10_001},
    '{2'd0, 3'd6, 16'h1040, 4'd2, 32'hA000_0200, 2'd2, 5'b00_110},
    '{2'd3, 3'd4, 16'h4300, 4'd4, 32'hD300_0300, 2'd1, 5'b11_100},
    '{2'd1, 3'd3, 16'h2100, 4'd1, 32'hB100_0400, 2'd0, 5'b01_011},
    '{2'd1, 3'd5, 16'h2180, 4'd4, 32'hB100_0500, 2'd3, 5'b01_101},
    '{2'd3, 3'd2, 16'h4380, 4'd2, 32'hD300_0600, 2'd0, 5'b11_010},
    '{2'd0, 3'd1, 16'h1100, 4'd3, 32'hA000_0700, 2'd1, 5'b00_001},
    '{2'd2, 3'd6, 16'h3200, 4'd2, 32'hC200_0800, 2'd2, 5'b10_110}
  };

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  run;
  slv_aw_chan_t [NP-1:0] slv_aw;
  logic [NP-1:0]         slv_aw_valid, slv_aw_ready;
  w_chan_t [NP-1:0]      slv_w;
  logic [NP-1:0]         slv_w_valid, slv_w_ready;
  slv_b_chan_t [NP-1:0]  slv_b;
  logic [NP-1:0]         slv_b_valid, slv_b_ready;
  mst_aw_chan_t          mst_aw;
  logic                  mst_aw_valid, mst_aw_ready;
  w_chan_t               mst_w;
  logic                  mst_w_valid, mst_w_ready;
  mst_b_chan_t           mst_b;
  logic                  mst_b_valid, mst_b_ready;

  // Port models
  slv_aw_chan_t aw_drv [NP];
  logic         aw_vld [NP];
  int           aw_cur [NP];   // Table entry shown on each port
  w_chan_t      w_drv  [NP];
  logic         w_vld  [NP];

  // Scoreboard, all queues hold table indices except the ID and beat queues
  int          aw_exp_q[$], w_exp_q[$], w_done_q[$], b_idx_q[$], b_exp_q[$];
  mst_id_t     slv_id_q[$], b_id_q[$];
  w_chan_t     w_obs_q[$];      // Shared W beats not yet matched to a peer AW
  int          b_cur_idx = 0;
  int          b_sent = 0;
  int          b_acked = 0;
  int          w_beat = 0;
  int          grant_cnt = 0;
  int          pre_w_cnt = 0;   // AWs accepted before the first W beat
  int          done_cnt = 0;
  int          cycle_cnt = 0;
  logic        w_seen = 1'b0;
  logic [NP-1:0] fair_mask = '0;
  int          err_aw = 0;
  int          err_w = 0;
  int          err_b = 0;
  int          err_misc = 0;
  logic [31:0] lfsr_q = 32'h0594_d927;

  always #2 clk = ~clk;

  axi_write_mux UUT (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .slv_aw_i       ( slv_aw       ),
    .slv_aw_valid_i ( slv_aw_valid ),
    .slv_aw_ready_o ( slv_aw_ready ),
    .slv_w_i        ( slv_w        ),
    .slv_w_valid_i  ( slv_w_valid  ),
    .slv_w_ready_o  ( slv_w_ready  ),
    .slv_b_o        ( slv_b        ),
    .slv_b_valid_o  ( slv_b_valid  ),
    .slv_b_ready_i  ( slv_b_ready  ),
    .mst_aw_o       ( mst_aw       ),
    .mst_aw_valid_o ( mst_aw_valid ),
    .mst_aw_ready_i ( mst_aw_ready ),
    .mst_w_o        ( mst_w        ),
    .mst_w_valid_o  ( mst_w_valid  ),
    .mst_w_ready_i  ( mst_w_ready  ),
    .mst_b_i        ( mst_b        ),
    .mst_b_valid_i  ( mst_b_valid  ),
    .mst_b_ready_o  ( mst_b_ready  )
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b      = lfsr_q[0];
  endtask

  task automatic print_counts();
    $display("Error counts: aw=%0d w=%0d b=%0d other=%0d, writes done %0d of %0d",
             err_aw, err_w, err_b, err_misc, done_cnt, N_WR);
  endtask

  // ----------------------------------------
  // Peer ports
  // ----------------------------------------
  for (genvar gp = 0; gp < NP; gp++) begin : g_port
    assign slv_aw[gp]       = aw_drv[gp];
    assign slv_aw_valid[gp] = aw_vld[gp];
    assign slv_w[gp]        = w_drv[gp];
    assign slv_w_valid[gp]  = w_vld[gp];

    // AW requests of this port in table order
    initial begin
      logic hs;
      aw_drv[gp] = '0;
      aw_vld[gp] = 1'b0;
      aw_cur[gp] = 0;
      wait (run);
      for (int i = 0; i < N_WR; i++) begin
        if (int'(tbl[i].port) == gp) begin
          aw_cur[gp] = i;
          aw_drv[gp] = '{id: tbl[i].id, addr: tbl[i].addr, len: 8'(tbl[i].beats) - 8'd1,
                         size: 3'd2, burst: 2'b01};
          aw_vld[gp] = 1'b1;
          do begin
            #1;
            hs = slv_aw_ready[gp];  // Sampled just before the rising edge
            @(negedge clk);
          end while (!hs);
          aw_vld[gp] = 1'b0;
        end
      end
    end

    // W bursts of this port, presented without waiting for the AW
    initial begin
      logic hs;
      w_drv[gp] = '0;
      w_vld[gp] = 1'b0;
      wait (run);
      for (int i = 0; i < N_WR; i++) begin
        if (int'(tbl[i].port) == gp) begin
          for (int b = 0; b < int'(tbl[i].beats); b++) begin
            w_drv[gp] = '{data: tbl[i].data + 32'(b), strb: 4'hF,
                          last: (b == int'(tbl[i].beats) - 1)};
            w_vld[gp] = 1'b1;
            do begin
              #1;
              hs = slv_w_ready[gp];
              @(negedge clk);
            end while (!hs);
          end
          w_vld[gp] = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Slave model
  // ----------------------------------------
  initial begin
    logic b0, b1;
    int   n;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    n = 0;
    wait (run);
    forever begin
      take_bit(b0);
      take_bit(b1);
      mst_aw_ready = b0 | b1;   // Ready three cycles out of four
      take_bit(b0);
      take_bit(b1);
      mst_w_ready = (n < W_HOLD) ? 1'b0 : (b0 | b1);
      n++;
      @(negedge clk);
    end
  end

  initial begin
    mst_b       = '0;
    mst_b_valid = 1'b0;
    wait (run);
    forever begin
      @(negedge clk);
      if (mst_b_valid && b_acked == b_sent) mst_b_valid = 1'b0;
      if (!mst_b_valid && b_idx_q.size() > 0) begin
        b_cur_idx   = b_idx_q.pop_front();
        mst_b.id    = b_id_q.pop_front();
        mst_b.resp  = tbl[b_cur_idx].resp;
        mst_b_valid = 1'b1;
        b_sent++;
      end
    end
  end

  // ----------------------------------------
  // Monitor, runs between the falling and the rising edge
  // ----------------------------------------
  task automatic check_cycle();
    int      idx;
    w_chan_t beat;
    // Peer B first, the register may refill in the same cycle
    if ($countones(slv_b_valid) > 1) begin
      $display("CHECK FAILED at %0t: B valid on several ports %b", $time, slv_b_valid);
      err_b++;
    end
    for (int p = 0; p < NP; p++) begin
      if (slv_b_valid[p] && slv_b_ready[p]) begin
        if (b_exp_q.size() == 0) begin
          $display("Response on port %0d at %0t with no response pending", p, $time);
          err_b++;
        end else begin
          idx = b_exp_q.pop_front();
          if (p != int'(tbl[idx].port)) begin
            $display("CHECK FAILED at %0t: write %0d answered on port %0d", $time, idx, p);
            err_b++;
          end
          if (slv_b[p].id != tbl[idx].id || slv_b[p].resp != tbl[idx].resp) begin
            $display("CHECK FAILED at %0t: write %0d B id %0d resp %0d", $time, idx,
                     slv_b[p].id, slv_b[p].resp);
            err_b++;
          end
          done_cnt++;
        end
      end
    end
    if (mst_b_valid && mst_b_ready) begin
      b_exp_q.push_back(b_cur_idx);
      b_acked++;
    end
    if (mst_aw_valid && mst_aw_ready) begin
      if (aw_exp_q.size() == 0) begin
        $display("Shared AW at %0t with no peer request accepted", $time);
        err_aw++;
      end else begin
        idx = aw_exp_q.pop_front();
        if (mst_aw.id != tbl[idx].mid) begin
          $display("CHECK FAILED at %0t: write %0d AW id %b", $time, idx, mst_aw.id);
          err_aw++;
        end
        if (mst_aw.addr != tbl[idx].addr || mst_aw.len != 8'(tbl[idx].beats) - 8'd1 ||
            mst_aw.size != 3'd2 || mst_aw.burst != 2'b01) begin
          $display("CHECK FAILED at %0t: write %0d AW fields %h", $time, idx, mst_aw);
          err_aw++;
        end
        slv_id_q.push_back(mst_aw.id);
      end
    end
    if (mst_w_valid && mst_w_ready) begin
      if (!w_seen && pre_w_cnt > `AXI_MUX_MAX_W_TRANS) begin
        $display("CHECK FAILED at %0t: %0d AWs accepted before first W", $time, pre_w_cnt);
        err_w++;
      end
      w_seen = 1'b1;
      w_obs_q.push_back(mst_w);
    end
    for (int p = 0; p < NP; p++) begin
      if (slv_aw_valid[p] && slv_aw_ready[p]) begin
        if (grant_cnt < NP) begin
          if (fair_mask[p]) begin
            $display("CHECK FAILED at %0t: port %0d granted twice in first round", $time, p);
            err_aw++;
          end
          fair_mask[p] = 1'b1;
        end
        grant_cnt++;
        if (!w_seen) pre_w_cnt++;
        aw_exp_q.push_back(aw_cur[p]);
        w_exp_q.push_back(aw_cur[p]);
      end
    end
    // A burst may start before its peer AW handshake while the grant is locked
    while (w_obs_q.size() > 0 && w_exp_q.size() > 0) begin
      beat = w_obs_q.pop_front();
      idx  = w_exp_q[0];
      if (beat.data != tbl[idx].data + 32'(w_beat) || beat.strb != 4'hF) begin
        $display("CHECK FAILED at %0t: write %0d beat %0d data %h", $time, idx, w_beat,
                 beat.data);
        err_w++;
      end
      if (beat.last != (w_beat == int'(tbl[idx].beats) - 1)) begin
        $display("CHECK FAILED at %0t: write %0d beat %0d last %b", $time, idx, w_beat,
                 beat.last);
        err_w++;
      end
      if (beat.last) begin
        void'(w_exp_q.pop_front());
        w_done_q.push_back(idx);
        w_beat = 0;
      end else begin
        w_beat++;
      end
    end
    // Slave answers once both the AW and the last W beat are in
    while (slv_id_q.size() > 0 && w_done_q.size() > 0) begin
      b_id_q.push_back(slv_id_q.pop_front());
      b_idx_q.push_back(w_done_q.pop_front());
    end
  endtask

  initial begin
    wait (run);
    forever begin
      #1;
      check_cycle();
      @(negedge clk);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout after %0d cycles, writes still open", cycle_cnt);
      print_counts();
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    run         = 1'b0;
    slv_b_ready = '1;
    repeat (RST_CYC) @(negedge clk);
    rst = 1'b0;
    run = 1'b1;
    wait (done_cnt == N_WR);
    repeat (8) @(negedge clk);
    if (aw_exp_q.size() != 0 || w_exp_q.size() != 0 || b_exp_q.size() != 0 ||
        b_idx_q.size() != 0 || w_obs_q.size() != 0) begin
      $display("Transactions left over after the last response");
      err_misc++;
    end
    if (grant_cnt != N_WR) begin
      $display("CHECK FAILED at %0t: %0d AWs accepted, %0d expected", $time, grant_cnt, N_WR);
      err_misc++;
    end
    print_counts();
    if (err_aw + err_w + err_b + err_misc == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== axi_write_mux_assert.sv ====
// Handshake and W routing FIFO assertions of the write multiplexer

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module axi_write_mux_assert (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_mux_pkg::mst_aw_chan_t  aw_i,
  input  logic                       aw_valid_i,
  input  logic                       aw_ready_i,
  input  axi_mux_pkg::w_chan_t       w_i,
  input  logic                       w_valid_i,
  input  logic                       w_ready_i,
  input  logic                       push_i,
  input  logic                       full_i,
  input  logic                       pop_i,
  input  logic                       empty_i
);

  localparam int unsigned DEPTH = `AXI_MUX_MAX_W_TRANS;

  logic [$clog2(DEPTH):0] occ_q;   // Fill level counted from push and pop

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      occ_q <= '0;
    end else if (push_i && !pop_i) begin
      occ_q <= occ_q + 1'b1;
    end else if (pop_i && !push_i) begin
      occ_q <= occ_q - 1'b1;
    end
  end

  // Shared port holds valid and payload until ready
  a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else $error("Shared AW dropped or changed before ready");

  a_w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
    else $error("Shared W dropped or changed before ready");

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> occ_q < DEPTH)
    else $error("Routing FIFO pushed while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> occ_q != 0)
    else $error("Routing FIFO popped while empty");

  a_fifo_flags: assert property (@(posedge clk_i) disable iff (rst_i)
    full_i == (occ_q == DEPTH) && empty_i == (occ_q == 0))
    else $error("Routing FIFO flags disagree with its fill level");

endmodule

bind axi_write_mux axi_write_mux_assert i_checks (
  .clk_i      ( clk_i          ),
  .rst_i      ( rst_i          ),
  .aw_i       ( mst_aw_o       ),
  .aw_valid_i ( mst_aw_valid_o ),
  .aw_ready_i ( mst_aw_ready_i ),
  .w_i        ( mst_w_o        ),
  .w_valid_i  ( mst_w_valid_o  ),
  .w_ready_i  ( mst_w_ready_i  ),
  .push_i     ( fifo_push      ),
  .full_i     ( fifo_full      ),
  .pop_i      ( fifo_pop       ),
  .empty_i    ( fifo_empty     )
);

// ==== axi_write_mux.sv ====
// AXI4 write multiplexer, four peer ports onto one shared port
// AW arbitration with ID prepend, W routed in AW order, B routed by ID

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module axi_write_mux (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  // Peer ports
  input  axi_mux_pkg::slv_aw_chan_t [`AXI_MUX_NUM_PORTS-1:0] slv_aw_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_aw_valid_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_aw_ready_o,
  input  axi_mux_pkg::w_chan_t [`AXI_MUX_NUM_PORTS-1:0]      slv_w_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_w_valid_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_w_ready_o,
  output axi_mux_pkg::slv_b_chan_t [`AXI_MUX_NUM_PORTS-1:0]  slv_b_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_b_valid_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_b_ready_i,
  // Shared port
  output axi_mux_pkg::mst_aw_chan_t                          mst_aw_o,
  output logic                                               mst_aw_valid_o,
  input  logic                                               mst_aw_ready_i,
  output axi_mux_pkg::w_chan_t                               mst_w_o,
  output logic                                               mst_w_valid_o,
  input  logic                                               mst_w_ready_i,
  input  axi_mux_pkg::mst_b_chan_t                           mst_b_i,
  input  logic                                               mst_b_valid_i,
  output logic                                               mst_b_ready_o
);
  import axi_mux_pkg::*;

  logic         gnt_valid, gnt_ready;
  mst_aw_chan_t gnt_aw;
  port_idx_t    gnt_idx;
  logic         fifo_full, fifo_empty;
  logic         fifo_push, fifo_pop;
  port_idx_t    fifo_idx, fifo_head;

  // ----------------------------------------
  // AW path
  // ----------------------------------------
  rr_arbiter i_aw_arbiter (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .req_valid_i ( slv_aw_valid_i ),
    .req_ready_o ( slv_aw_ready_o ),
    .req_aw_i    ( slv_aw_i       ),
    .gnt_valid_o ( gnt_valid      ),
    .gnt_ready_i ( gnt_ready      ),
    .gnt_aw_o    ( gnt_aw         ),
    .gnt_idx_o   ( gnt_idx        )
  );

  aw_channel_ctrl i_aw_ctrl (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .gnt_valid_i    ( gnt_valid      ),
    .gnt_ready_o    ( gnt_ready      ),
    .gnt_aw_i       ( gnt_aw         ),
    .gnt_idx_i      ( gnt_idx        ),
    .fifo_full_i    ( fifo_full      ),
    .fifo_push_o    ( fifo_push      ),
    .fifo_idx_o     ( fifo_idx       ),
    .mst_aw_o       ( mst_aw_o       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i )
  );

  // ----------------------------------------
  // W path
  // ----------------------------------------
  w_route_fifo i_w_fifo (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .push_i  ( fifo_push  ),
    .idx_i   ( fifo_idx   ),
    .full_o  ( fifo_full  ),
    .pop_i   ( fifo_pop   ),
    .head_o  ( fifo_head  ),
    .empty_o ( fifo_empty )
  );

  w_channel_mux i_w_mux (
    .slv_w_i       ( slv_w_i       ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .head_i        ( fifo_head     ),
    .empty_i       ( fifo_empty    ),
    .pop_o         ( fifo_pop      ),
    .mst_w_o       ( mst_w_o       ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  // B path
  b_resp_router i_b_router (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .mst_b_i       ( mst_b_i       ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_o       ( slv_b_o       ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

endmodule

// ==== b_resp_router.sv ====
// B response router
// One-entry register, routes by the index bits of the ID and strips them

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module b_resp_router (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  axi_mux_pkg::mst_b_chan_t                           mst_b_i,
  input  logic                                               mst_b_valid_i,
  output logic                                               mst_b_ready_o,
  output axi_mux_pkg::slv_b_chan_t [`AXI_MUX_NUM_PORTS-1:0]  slv_b_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_b_valid_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                      slv_b_ready_i
);
  import axi_mux_pkg::*;

  mst_b_chan_t b_q;
  logic        b_full_q;
  port_idx_t   b_idx;
  logic        b_load, b_drain;

  assign b_idx   = b_q.id[`AXI_MUX_MST_ID_WIDTH-1 -: `AXI_MUX_IDX_WIDTH];
  assign b_drain = b_full_q & slv_b_ready_i[b_idx];
  assign b_load  = mst_b_valid_i & mst_b_ready_o;

  // Free now or freed by the addressed port this cycle
  assign mst_b_ready_o = ~b_full_q | b_drain;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_full_q <= 1'b0;
    end else if (b_load) begin
      b_full_q <= 1'b1;
    end else if (b_drain) begin
      b_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_load) b_q <= mst_b_i;
  end

  // Same stripped response on every port, only one sees valid
  always_comb begin
    slv_b_valid_o        = '0;
    slv_b_valid_o[b_idx] = b_full_q;
    for (int p = 0; p < `AXI_MUX_NUM_PORTS; p++) begin
      slv_b_o[p].id   = b_q.id[`AXI_MUX_SLV_ID_WIDTH-1:0];
      slv_b_o[p].resp = b_q.resp;
    end
  end

endmodule

// ==== w_channel_mux.sv ====
// W channel steering
// Connects the port at the FIFO head to the shared W port, pops on the last beat

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module w_channel_mux (
  input  axi_mux_pkg::w_chan_t [`AXI_MUX_NUM_PORTS-1:0] slv_w_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                 slv_w_valid_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                 slv_w_ready_o,
  input  axi_mux_pkg::port_idx_t                        head_i,
  input  logic                                          empty_i,
  output logic                                          pop_o,
  output axi_mux_pkg::w_chan_t                          mst_w_o,
  output logic                                          mst_w_valid_o,
  input  logic                                          mst_w_ready_i
);
  import axi_mux_pkg::*;

  w_chan_t head_w;
  logic    head_valid;

  assign head_w     = slv_w_i[head_i];
  assign head_valid = ~empty_i & slv_w_valid_i[head_i];  // Nothing routed while empty

  assign mst_w_o       = head_w;
  assign mst_w_valid_o = head_valid;

  // Other ports see no ready and wait their turn
  always_comb begin
    slv_w_ready_o         = '0;
    slv_w_ready_o[head_i] = ~empty_i & mst_w_ready_i;
  end

  assign pop_o = head_valid & mst_w_ready_i & head_w.last;  // Burst done

endmodule

// ==== w_route_fifo.sv ====
// W routing FIFO
// Keeps the port index of every accepted AW in grant order

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module w_route_fifo (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    push_i,
  input  axi_mux_pkg::port_idx_t  idx_i,
  output logic                    full_o,
  input  logic                    pop_i,
  output axi_mux_pkg::port_idx_t  head_o,
  output logic                    empty_o
);
  import axi_mux_pkg::*;

  localparam int unsigned DEPTH = `AXI_MUX_MAX_W_TRANS;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  port_idx_t        mem_q [DEPTH];
  logic [PTR_W:0]   wr_ptr_q, rd_ptr_q;   // Extra wrap bit tells full from empty
  logic             do_push, do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign head_o  = mem_q[rd_ptr_q[PTR_W-1:0]];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[PTR_W-1:0]] <= idx_i;
    end
  end

endmodule

// ==== aw_channel_ctrl.sv ====
// AW channel control of the write multiplexer
// Pushes the grant order into the W routing FIFO and feeds a two-entry spill stage

`timescale 1ns/1ps

module aw_channel_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       gnt_valid_i,
  output logic                       gnt_ready_o,
  input  axi_mux_pkg::mst_aw_chan_t  gnt_aw_i,
  input  axi_mux_pkg::port_idx_t     gnt_idx_i,
  input  logic                       fifo_full_i,
  output logic                       fifo_push_o,
  output axi_mux_pkg::port_idx_t     fifo_idx_o,
  output axi_mux_pkg::mst_aw_chan_t  mst_aw_o,
  output logic                       mst_aw_valid_o,
  input  logic                       mst_aw_ready_i
);
  import axi_mux_pkg::*;

  aw_state_e    state_q, state_d;
  logic         spill_valid, spill_ready;
  logic         a_full_q, b_full_q;
  mst_aw_chan_t a_data_q, b_data_q;
  logic         a_fill, a_drain, b_fill, b_drain;

  assign fifo_idx_o = gnt_idx_i;

  // ----------------------------------------
  // Lock FSM
  // ----------------------------------------
  always_comb begin
    state_d     = state_q;
    spill_valid = 1'b0;
    gnt_ready_o = 1'b0;
    fifo_push_o = 1'b0;
    case (state_q)
      AW_IDLE: begin
        if (gnt_valid_i && !fifo_full_i) begin
          spill_valid = 1'b1;
          fifo_push_o = 1'b1;          // Index recorded once per grant
          if (spill_ready) begin
            gnt_ready_o = 1'b1;
          end else begin
            state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // Already pushed, only wait for the spill stage
        spill_valid = 1'b1;
        if (spill_ready) begin
          gnt_ready_o = 1'b1;
          state_d     = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // Spill stage
  // ----------------------------------------
  // Entry A takes new requests, B catches A under back-pressure
  assign spill_ready = ~a_full_q | ~b_full_q;
  assign a_fill      = spill_valid & spill_ready;
  assign a_drain     = a_full_q & ~b_full_q;
  assign b_fill      = a_drain & ~mst_aw_ready_i;
  assign b_drain     = b_full_q & mst_aw_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= gnt_aw_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  assign mst_aw_valid_o = a_full_q | b_full_q;
  assign mst_aw_o       = b_full_q ? b_data_q : a_data_q;  // B is always the older one

endmodule

// ==== rr_arbiter.sv ====
// Round-robin AW arbiter over the peer ports
// Holds its choice while a grant is pending and prepends the port index to the ID

`timescale 1ns/1ps
`include "axi_mux_settings.svh"

module rr_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                    req_valid_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                    req_ready_o,
  input  axi_mux_pkg::slv_aw_chan_t [`AXI_MUX_NUM_PORTS-1:0] req_aw_i,
  output logic                                             gnt_valid_o,
  input  logic                                             gnt_ready_i,
  output axi_mux_pkg::mst_aw_chan_t                        gnt_aw_o,
  output axi_mux_pkg::port_idx_t                           gnt_idx_o
);
  import axi_mux_pkg::*;

  port_idx_t rr_q;         // First port to look at
  port_idx_t lock_idx_q;   // Port held while its grant waits
  logic      lock_q;
  port_idx_t pick;         // Free choice when not locked
  logic      found;
  port_idx_t sel;
  port_idx_t sel_next;

  // Search from the pointer upwards with wrap-around
  always_comb begin
    port_idx_t cand;
    found = 1'b0;
    pick  = rr_q;
    cand  = rr_q;
    for (int k = 0; k < `AXI_MUX_NUM_PORTS; k++) begin
      cand = port_idx_t'((int'(rr_q) + k) % `AXI_MUX_NUM_PORTS);
      if (!found && req_valid_i[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  assign sel         = lock_q ? lock_idx_q : pick;
  assign gnt_valid_o = req_valid_i[sel];   // Low when nothing was found
  assign gnt_idx_o   = sel;
  assign sel_next    = (sel == port_idx_t'(`AXI_MUX_NUM_PORTS - 1)) ? '0 : sel + 1'b1;

  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = gnt_valid_o & gnt_ready_i;
  end

  // Winner's payload with its index on top of the ID
  always_comb begin
    gnt_aw_o.id    = {sel, req_aw_i[sel].id};
    gnt_aw_o.addr  = req_aw_i[sel].addr;
    gnt_aw_o.len   = req_aw_i[sel].len;
    gnt_aw_o.size  = req_aw_i[sel].size;
    gnt_aw_o.burst = req_aw_i[sel].burst;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (gnt_valid_o && gnt_ready_i) begin
      lock_q <= 1'b0;
      rr_q   <= sel_next;     // Move past the port just served
    end else if (gnt_valid_o) begin
      lock_q     <= 1'b1;     // Shown but not taken, keep it
      lock_idx_q <= sel;
    end
  end

endmodule

// ==== axi_mux_pkg.sv ====
// Channel types of the AXI4 write multiplexer
// Peer-side and shared-side structs, port index and AW lock state

`include "axi_mux_settings.svh"

package axi_mux_pkg;

  typedef logic [`AXI_MUX_IDX_WIDTH-1:0]      port_idx_t;
  typedef logic [`AXI_MUX_SLV_ID_WIDTH-1:0]   slv_id_t;
  typedef logic [`AXI_MUX_MST_ID_WIDTH-1:0]   mst_id_t;
  typedef logic [`AXI_MUX_ADDR_WIDTH-1:0]     addr_t;
  typedef logic [`AXI_MUX_DATA_WIDTH-1:0]     data_t;
  typedef logic [`AXI_MUX_DATA_WIDTH/8-1:0]   strb_t;

  // ----------------------------------------
  // AW channel, ID is the top field
  // ----------------------------------------
  typedef struct packed {
    slv_id_t     id;
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;  // Plain field, no decoding here
  } slv_aw_chan_t;

  typedef struct packed {
    mst_id_t     id;     // Port index in the top bits
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } mst_aw_chan_t;

  typedef struct packed {
    data_t  data;
    strb_t  strb;
    logic   last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t     id;
    logic [1:0]  resp;
  } slv_b_chan_t;

  typedef struct packed {
    mst_id_t     id;
    logic [1:0]  resp;
  } mst_b_chan_t;

  // Grant pushed to the W FIFO but still waiting for the spill stage
  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

endpackage

// ==== axi_mux_settings.svh ====
// Compile-time settings of the AXI4 write multiplexer
// Port count, ID, address and data widths, W routing depth

`ifndef AXI_MUX_SETTINGS_SVH
`define AXI_MUX_SETTINGS_SVH

// Peer ports and the index that names them
`define AXI_MUX_NUM_PORTS     4
`define AXI_MUX_IDX_WIDTH     2

// ID widths, the shared port carries the port index on top
`define AXI_MUX_SLV_ID_WIDTH  3
`define AXI_MUX_MST_ID_WIDTH  (`AXI_MUX_SLV_ID_WIDTH + `AXI_MUX_IDX_WIDTH)

`define AXI_MUX_ADDR_WIDTH    16
`define AXI_MUX_DATA_WIDTH    32  // Strobe is one bit per byte

`define AXI_MUX_MAX_W_TRANS   4   // Outstanding AWs waiting for W data

`endif
